// ==== Bender.yml ====
package:
  name: hpm_unit

sources:
  - include_dirs:
      - source
    files:
      - source/hpm_pkg.sv
      - source/hpm_event_select.sv
      - source/hpm_counter_bank.sv
      - source/hpm_csr_bridge.sv
      - source/hpm_unit.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/hpm_unit_tb.sv

// ==== hpm_unit.f ====
+incdir+source
source/hpm_pkg.sv
source/hpm_event_select.sv
source/hpm_counter_bank.sv
source/hpm_csr_bridge.sv
source/hpm_unit.sv
test/hpm_unit_tb.sv

// ==== source/hpm_config.svh ====
// Fixed for XLEN 32 and six counters; the address bases assume the standard mhpm CSR map
`ifndef HPM_CONFIG_SVH
`define HPM_CONFIG_SVH

// Programmable counters mhpmcounter3 and up
`define HPM_NUM_COUNTERS 6

// Commit ports of the core
`define HPM_NR_COMMIT 2

// CSR address of the first counter in each range
`define HPM_CNT_LO_BASE 12'hB03
`define HPM_CNT_HI_BASE 12'hB83
`define HPM_EVT_BASE    12'h323

// Data word and counter widths
`define HPM_XLEN  32
`define HPM_CNT_W 64

`endif

// ==== source/hpm_counter_bank.sv ====
// Read response is decoded from req_i every cycle; only access_i with we applies a write
`timescale 1ns/1ns
`include "hpm_config.svh"

module hpm_counter_bank (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          access_i,
  input  hpm_pkg::csr_req_t                             req_i,
  output hpm_pkg::csr_rsp_t                             rsp_o,
  input  logic                  [`HPM_NUM_COUNTERS-1:0] events_i,
  input  logic                                          debug_mode_i,
  input  hpm_pkg::xlen_t                                mcountinhibit_i,
  output hpm_pkg::event_sel_t   [`HPM_NUM_COUNTERS-1:0] selectors_o
);

  hpm_pkg::counter_t   [`HPM_NUM_COUNTERS-1:0] cnt_d;
  hpm_pkg::counter_t   [`HPM_NUM_COUNTERS-1:0] cnt_q;
  hpm_pkg::event_sel_t [`HPM_NUM_COUNTERS-1:0] sel_d;
  hpm_pkg::event_sel_t [`HPM_NUM_COUNTERS-1:0] sel_q;

  hpm_pkg::csr_addr_t lo_off;
  hpm_pkg::csr_addr_t hi_off;
  hpm_pkg::csr_addr_t evt_off;
  logic               lo_hit;
  logic               hi_hit;
  logic               evt_hit;
  logic               wr_strobe;

  // Offsets wrap below the base, so one unsigned compare covers each range
  assign lo_off  = req_i.addr - `HPM_CNT_LO_BASE;
  assign hi_off  = req_i.addr - `HPM_CNT_HI_BASE;
  assign evt_off = req_i.addr - `HPM_EVT_BASE;
  assign lo_hit  = lo_off < `HPM_NUM_COUNTERS;
  assign hi_hit  = hi_off < `HPM_NUM_COUNTERS;
  assign evt_hit = evt_off < `HPM_NUM_COUNTERS;

  assign wr_strobe   = access_i && req_i.we;
  assign selectors_o = sel_q;

  always_comb begin : read_decode
    rsp_o = '0;
    if (lo_hit) begin
      rsp_o.rdata = cnt_q[lo_off[2:0]][`HPM_XLEN-1:0];
    end else if (hi_hit) begin
      rsp_o.rdata = cnt_q[hi_off[2:0]][`HPM_CNT_W-1:`HPM_XLEN];
    end else if (evt_hit) begin
      rsp_o.rdata = hpm_pkg::xlen_t'(sel_q[evt_off[2:0]]);
    end else begin
      rsp_o.err = 1'b1;  // Unmapped, data stays zero
    end
  end

  always_comb begin : next_state
    cnt_d = cnt_q;
    sel_d = sel_q;

    // Counter k sits at mcountinhibit bit k+3
    for (int k = 0; k < `HPM_NUM_COUNTERS; k++) begin
      if (!debug_mode_i && !wr_strobe && events_i[k] && !mcountinhibit_i[k+3]) begin
        cnt_d[k] = cnt_q[k] + 1'b1;
      end
    end

    if (wr_strobe) begin
      if (lo_hit) begin
        cnt_d[lo_off[2:0]][`HPM_XLEN-1:0] = req_i.wdata;
      end else if (hi_hit) begin
        cnt_d[hi_off[2:0]][`HPM_CNT_W-1:`HPM_XLEN] = req_i.wdata;
      end else if (evt_hit) begin
        sel_d[evt_off[2:0]] = req_i.wdata[4:0];  // Keep low 5 bits
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : regs
    if (!rst_ni) begin
      cnt_q <= '0;
      sel_q <= '0;
    end else begin
      cnt_q <= cnt_d;
      sel_q <= sel_d;
    end
  end

  sel_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(selectors_o));

  // Counting is paused on the strobe too, so nothing may move
  unmapped_write_no_effect: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wr_strobe && rsp_o.err) |=> ($stable(cnt_q) && $stable(sel_q)));

endmodule

// ==== source/hpm_csr_bridge.sv ====
// One access in flight; the requester must hold csr_req_i stable while csr_valid_i is high
`timescale 1ns/1ns

module hpm_csr_bridge (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              csr_valid_i,
  input  hpm_pkg::csr_req_t csr_req_i,
  output logic              csr_ack_o,
  output hpm_pkg::csr_rsp_t csr_rsp_o,
  output logic              access_o,
  output hpm_pkg::csr_req_t bank_req_o,
  input  hpm_pkg::csr_rsp_t bank_rsp_i
);

  hpm_pkg::bridge_state_e state_q;
  hpm_pkg::csr_req_t      req_q;
  hpm_pkg::csr_rsp_t      rsp_q;
  logic                   ack_q;

  assign access_o   = state_q == hpm_pkg::BR_ACCESS;  // Single strobe cycle
  assign bank_req_o = req_q;
  assign csr_ack_o  = ack_q;
  assign csr_rsp_o  = rsp_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : fsm
    if (!rst_ni) begin
      state_q <= hpm_pkg::BR_IDLE;
      ack_q   <= 1'b0;
      rsp_q   <= '0;
    end else begin
      unique case (state_q)
        hpm_pkg::BR_IDLE: begin
          if (csr_valid_i) state_q <= hpm_pkg::BR_ACCESS;
        end
        hpm_pkg::BR_ACCESS: begin
          rsp_q   <= bank_rsp_i;  // Held until next access
          state_q <= hpm_pkg::BR_ACK;
        end
        hpm_pkg::BR_ACK: begin
          // Ack follows valid until the requester releases it
          if (csr_valid_i) begin
            ack_q <= 1'b1;
          end else begin
            ack_q   <= 1'b0;
            state_q <= hpm_pkg::BR_IDLE;
          end
        end
        default: state_q <= hpm_pkg::BR_IDLE;
      endcase
    end
  end

  // Request capture on entry to BR_ACCESS
  always_ff @(posedge clk_i) begin : capture
    if (state_q == hpm_pkg::BR_IDLE && csr_valid_i) req_q <= csr_req_i;
  end

  ack_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(csr_ack_o) |-> csr_valid_i);

  single_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
    access_o |=> !access_o);

endmodule

// ==== source/hpm_event_select.sv ====
// Purely combinational; commit events only see ports with commit_ack_i set, codes 16 to 31 give 0
`timescale 1ns/1ns
`include "hpm_config.svh"

module hpm_event_select (
  input  hpm_pkg::event_sel_t    [`HPM_NUM_COUNTERS-1:0] selectors_i,
  input  hpm_pkg::core_status_t                          status_i,
  input  hpm_pkg::commit_instr_t [`HPM_NR_COMMIT-1:0]    commit_instr_i,
  input  logic                   [`HPM_NR_COMMIT-1:0]    commit_ack_i,
  output logic                   [`HPM_NUM_COUNTERS-1:0] events_o
);

  // Any acknowledged port matching, at most one count per cycle
  logic commit_load;
  logic commit_store;
  logic commit_branch;
  logic commit_call;
  logic commit_return;
  logic commit_int;

  always_comb begin : commit_match
    commit_load   = 1'b0;
    commit_store  = 1'b0;
    commit_branch = 1'b0;
    commit_call   = 1'b0;
    commit_return = 1'b0;
    commit_int    = 1'b0;
    for (int p = 0; p < `HPM_NR_COMMIT; p++) begin
      if (commit_ack_i[p]) begin
        commit_load   |= commit_instr_i[p].fu == hpm_pkg::FU_LOAD;
        commit_store  |= commit_instr_i[p].fu == hpm_pkg::FU_STORE;
        commit_branch |= commit_instr_i[p].fu == hpm_pkg::FU_CTRL_FLOW;
        // Link register x1 or x5 marks a call
        commit_call   |= (commit_instr_i[p].fu == hpm_pkg::FU_CTRL_FLOW) &&
                         (commit_instr_i[p].rd == 5'd1 || commit_instr_i[p].rd == 5'd5);
        commit_return |= commit_instr_i[p].is_jalr && (commit_instr_i[p].rd == 5'd0);
        commit_int    |= (commit_instr_i[p].fu == hpm_pkg::FU_ALU) ||
                         (commit_instr_i[p].fu == hpm_pkg::FU_MULT);
      end
    end
  end

  always_comb begin : event_mux
    for (int k = 0; k < `HPM_NUM_COUNTERS; k++) begin
      case (hpm_pkg::event_code_e'(selectors_i[k]))
        hpm_pkg::EV_ICACHE_MISS: events_o[k] = status_i.icache_miss;
        hpm_pkg::EV_DCACHE_MISS: events_o[k] = status_i.dcache_miss;
        hpm_pkg::EV_ITLB_MISS:   events_o[k] = status_i.itlb_miss;
        hpm_pkg::EV_DTLB_MISS:   events_o[k] = status_i.dtlb_miss;
        hpm_pkg::EV_LOAD:        events_o[k] = commit_load;
        hpm_pkg::EV_STORE:       events_o[k] = commit_store;
        hpm_pkg::EV_EXCEPTION:   events_o[k] = status_i.exception;
        hpm_pkg::EV_ERET:        events_o[k] = status_i.eret;
        hpm_pkg::EV_BRANCH:      events_o[k] = commit_branch;
        hpm_pkg::EV_CALL:        events_o[k] = commit_call;
        hpm_pkg::EV_RETURN:      events_o[k] = commit_return;
        hpm_pkg::EV_SB_FULL:     events_o[k] = status_i.sb_full;
        hpm_pkg::EV_IF_EMPTY:    events_o[k] = status_i.if_empty;
        hpm_pkg::EV_INT_INSTR:   events_o[k] = commit_int;
        hpm_pkg::EV_STALL:       events_o[k] = status_i.stall_issue;
        default:                 events_o[k] = 1'b0;  // EV_NONE and unassigned codes
      endcase
    end
  end

endmodule

// ==== source/hpm_pkg.sv ====
// Shared types; widths come from hpm_config.svh and event codes 16 to 31 are left unassigned
`include "hpm_config.svh"

package hpm_pkg;

  typedef logic [`HPM_XLEN-1:0]  xlen_t;
  typedef logic [11:0]           csr_addr_t;
  typedef logic [`HPM_CNT_W-1:0] counter_t;
  typedef logic [4:0]            event_sel_t;  // Upper write bits dropped
  typedef logic [4:0]            reg_idx_t;

  typedef enum logic [2:0] {
    FU_NONE,
    FU_ALU,
    FU_MULT,
    FU_LOAD,
    FU_STORE,
    FU_CTRL_FLOW,
    FU_FPU
  } fu_t;

  typedef struct packed {
    fu_t      fu;
    reg_idx_t rd;
    logic     is_jalr;
  } commit_instr_t;

  // One pulse per event from the core
  typedef struct packed {
    logic icache_miss;
    logic dcache_miss;
    logic itlb_miss;
    logic dtlb_miss;
    logic exception;
    logic eret;
    logic sb_full;
    logic if_empty;
    logic stall_issue;
  } core_status_t;

  typedef struct packed {
    csr_addr_t addr;
    logic      we;
    xlen_t     wdata;
  } csr_req_t;

  typedef struct packed {
    xlen_t rdata;
    logic  err;
  } csr_rsp_t;

  typedef enum logic [4:0] {
    EV_NONE        = 5'd0,
    EV_ICACHE_MISS = 5'd1,
    EV_DCACHE_MISS = 5'd2,
    EV_ITLB_MISS   = 5'd3,
    EV_DTLB_MISS   = 5'd4,
    EV_LOAD        = 5'd5,
    EV_STORE       = 5'd6,
    EV_EXCEPTION   = 5'd7,
    EV_ERET        = 5'd8,
    EV_BRANCH      = 5'd9,
    EV_CALL        = 5'd10,
    EV_RETURN      = 5'd11,
    EV_SB_FULL     = 5'd12,
    EV_IF_EMPTY    = 5'd13,
    EV_INT_INSTR   = 5'd14,
    EV_STALL       = 5'd15
  } event_code_e;

  typedef enum logic [1:0] {
    BR_IDLE,
    BR_ACCESS,
    BR_ACK
  } bridge_state_e;

endpackage

// ==== source/hpm_unit.sv ====
// Core status and commit records are taken as plain inputs; no privilege checks or interrupts
`timescale 1ns/1ns
`include "hpm_config.svh"

module hpm_unit (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        csr_valid_i,
  input  hpm_pkg::csr_req_t                           csr_req_i,
  output logic                                        csr_ack_o,
  output hpm_pkg::csr_rsp_t                           csr_rsp_o,
  input  hpm_pkg::core_status_t                       status_i,
  input  hpm_pkg::commit_instr_t [`HPM_NR_COMMIT-1:0] commit_instr_i,
  input  logic                   [`HPM_NR_COMMIT-1:0] commit_ack_i,
  input  logic                                        debug_mode_i,
  input  hpm_pkg::xlen_t                              mcountinhibit_i
);

  logic                                        access;
  hpm_pkg::csr_req_t                           bank_req;
  hpm_pkg::csr_rsp_t                           bank_rsp;
  hpm_pkg::event_sel_t [`HPM_NUM_COUNTERS-1:0] selectors;
  logic                [`HPM_NUM_COUNTERS-1:0] events;

  hpm_csr_bridge i_bridge (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .csr_valid_i(csr_valid_i),
    .csr_req_i  (csr_req_i),
    .csr_ack_o  (csr_ack_o),
    .csr_rsp_o  (csr_rsp_o),
    .access_o   (access),
    .bank_req_o (bank_req),
    .bank_rsp_i (bank_rsp)
  );

  hpm_counter_bank i_bank (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .access_i       (access),
    .req_i          (bank_req),
    .rsp_o          (bank_rsp),
    .events_i       (events),
    .debug_mode_i   (debug_mode_i),
    .mcountinhibit_i(mcountinhibit_i),
    .selectors_o    (selectors)
  );

  hpm_event_select i_event_select (
    .selectors_i   (selectors),
    .status_i      (status_i),
    .commit_instr_i(commit_instr_i),
    .commit_ack_i  (commit_ack_i),
    .events_o      (events)
  );

endmodule

// ==== test/hpm_unit_tb.sv ====
// Event inputs idle during CSR accesses so the model skips strobe cycles; seed is fixed
`timescale 1ns/1ns
`include "hpm_config.svh"

module hpm_unit_tb;

  localparam int ack_timeout = 20;  // Cycles per handshake phase

  logic                                        clk_i = 1'b0;
  logic                                        rst_ni;
  logic                                        csr_valid_i;
  hpm_pkg::csr_req_t                           csr_req_i;
  logic                                        csr_ack_o;
  hpm_pkg::csr_rsp_t                           csr_rsp_o;
  hpm_pkg::core_status_t                       status_i;
  hpm_pkg::commit_instr_t [`HPM_NR_COMMIT-1:0] commit_instr_i;
  logic                   [`HPM_NR_COMMIT-1:0] commit_ack_i;
  logic                                        debug_mode_i;
  hpm_pkg::xlen_t                              mcountinhibit_i;

  integer              seed = 32'h5021_ccef;
  hpm_pkg::counter_t   model_cnt [`HPM_NUM_COUNTERS];
  hpm_pkg::event_sel_t model_sel [`HPM_NUM_COUNTERS];
  int                  req_count = 0;
  int                  ack_count = 0;
  logic                ack_seen = 1'b0;
  hpm_pkg::csr_rsp_t   rsp_seen;

  always #2 clk_i = ~clk_i;

  hpm_unit hpm_unit_i (.*);

  task automatic end_with_failure();
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    end_with_failure();
  endtask

  task automatic check_data(input hpm_pkg::xlen_t got, input hpm_pkg::xlen_t exp,
                            input string what);
    if (got !== exp) report_mismatch($sformatf("%s is 0x%08h, expected 0x%08h", what, got, exp));
  endtask

  task automatic check_err(input logic got, input logic exp, input string what);
    if (got !== exp) report_mismatch($sformatf("%s err is %b, expected %b", what, got, exp));
  endtask

  task automatic check_counter(input hpm_pkg::counter_t got, input hpm_pkg::counter_t exp,
                               input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s is 0x%016h, expected 0x%016h", what, got, exp));
    end
  endtask

  // Reference decode of one event code
  function automatic logic expected_event(input hpm_pkg::event_sel_t code,
                                          input hpm_pkg::core_status_t st,
                                          input hpm_pkg::commit_instr_t [`HPM_NR_COMMIT-1:0] ci,
                                          input logic [`HPM_NR_COMMIT-1:0] ack);
    logic hit;
    hit = 1'b0;
    case (code)
      hpm_pkg::EV_ICACHE_MISS: hit = st.icache_miss;
      hpm_pkg::EV_DCACHE_MISS: hit = st.dcache_miss;
      hpm_pkg::EV_ITLB_MISS:   hit = st.itlb_miss;
      hpm_pkg::EV_DTLB_MISS:   hit = st.dtlb_miss;
      hpm_pkg::EV_EXCEPTION:   hit = st.exception;
      hpm_pkg::EV_ERET:        hit = st.eret;
      hpm_pkg::EV_SB_FULL:     hit = st.sb_full;
      hpm_pkg::EV_IF_EMPTY:    hit = st.if_empty;
      hpm_pkg::EV_STALL:       hit = st.stall_issue;
      default:                 hit = 1'b0;
    endcase
    for (int p = 0; p < `HPM_NR_COMMIT; p++) begin
      if (ack[p]) begin
        case (code)
          hpm_pkg::EV_LOAD:   hit |= ci[p].fu == hpm_pkg::FU_LOAD;
          hpm_pkg::EV_STORE:  hit |= ci[p].fu == hpm_pkg::FU_STORE;
          hpm_pkg::EV_BRANCH: hit |= ci[p].fu == hpm_pkg::FU_CTRL_FLOW;
          hpm_pkg::EV_CALL:   hit |= ci[p].fu == hpm_pkg::FU_CTRL_FLOW &&
                                     (ci[p].rd == 5'd1 || ci[p].rd == 5'd5);
          hpm_pkg::EV_RETURN: hit |= ci[p].is_jalr && ci[p].rd == 5'd0;
          hpm_pkg::EV_INT_INSTR: hit |= ci[p].fu == hpm_pkg::FU_ALU ||
                                        ci[p].fu == hpm_pkg::FU_MULT;
          default: ;
        endcase
      end
    end
    return hit;
  endfunction

  function automatic bit is_mapped(input hpm_pkg::csr_addr_t a);
    return (a >= `HPM_CNT_LO_BASE && a < `HPM_CNT_LO_BASE + `HPM_NUM_COUNTERS) ||
           (a >= `HPM_CNT_HI_BASE && a < `HPM_CNT_HI_BASE + `HPM_NUM_COUNTERS) ||
           (a >= `HPM_EVT_BASE && a < `HPM_EVT_BASE + `HPM_NUM_COUNTERS);
  endfunction

  function automatic hpm_pkg::csr_addr_t csr_addr(input hpm_pkg::csr_addr_t base, input int k);
    return hpm_pkg::csr_addr_t'(base + k);
  endfunction

  // Full four-phase handshake with the response sampled while ack is high
  task automatic csr_access(input hpm_pkg::csr_addr_t addr, input logic we,
                            input hpm_pkg::xlen_t wdata, output hpm_pkg::csr_rsp_t rsp);
    hpm_pkg::csr_req_t req;
    bit                done;
    req.addr  = addr;
    req.we    = we;
    req.wdata = wdata;
    @(posedge clk_i);
    csr_req_i   <= req;
    csr_valid_i <= 1'b1;
    req_count++;
    done = 1'b0;
    for (int i = 0; i < ack_timeout && !done; i++) begin
      @(negedge clk_i);
      done = csr_ack_o;
    end
    if (!done) begin
      $display("CSR handshake timed out waiting for ack to rise");
      end_with_failure();
    end
    rsp = csr_rsp_o;
    @(posedge clk_i);
    csr_valid_i <= 1'b0;
    done = 1'b0;
    for (int i = 0; i < ack_timeout && !done; i++) begin
      @(negedge clk_i);
      done = !csr_ack_o;
    end
    if (!done) begin
      $display("CSR handshake timed out waiting for ack to fall");
      end_with_failure();
    end
    if (ack_count != req_count) report_mismatch("acknowledge count differs from request count");
  endtask

  task automatic write_csr(input hpm_pkg::csr_addr_t addr, input hpm_pkg::xlen_t data);
    hpm_pkg::csr_rsp_t rsp;
    csr_access(addr, 1'b1, data, rsp);
    check_err(rsp.err, 1'b0, $sformatf("write 0x%03h", addr));
  endtask

  task automatic read_csr(input hpm_pkg::csr_addr_t addr, output hpm_pkg::xlen_t data);
    hpm_pkg::csr_rsp_t rsp;
    csr_access(addr, 1'b0, '0, rsp);
    check_err(rsp.err, 1'b0, $sformatf("read 0x%03h", addr));
    data = rsp.rdata;
  endtask

  task automatic check_all();
    hpm_pkg::xlen_t lo;
    hpm_pkg::xlen_t hi;
    hpm_pkg::xlen_t sel;
    for (int k = 0; k < `HPM_NUM_COUNTERS; k++) begin
      read_csr(csr_addr(`HPM_CNT_LO_BASE, k), lo);
      read_csr(csr_addr(`HPM_CNT_HI_BASE, k), hi);
      read_csr(csr_addr(`HPM_EVT_BASE, k), sel);
      check_counter({hi, lo}, model_cnt[k], $sformatf("mhpmcounter%0d", k + 3));
      check_data(sel, hpm_pkg::xlen_t'(model_sel[k]), $sformatf("mhpmevent%0d", k + 3));
    end
  endtask

  task automatic probe_unmapped(input hpm_pkg::csr_addr_t a);
    hpm_pkg::csr_rsp_t rsp;
    if (!is_mapped(a)) begin
      csr_access(a, 1'($random(seed)), $random(seed), rsp);
      check_err(rsp.err, 1'b1, $sformatf("unmapped 0x%03h", a));
      check_data(rsp.rdata, '0, $sformatf("unmapped 0x%03h data", a));
    end
  endtask

  // Random core traffic; the model counts what the DUT samples at the next edge
  task automatic run_traffic(input int cycles, input bit inhibit_on, input bit debug_on);
    hpm_pkg::core_status_t                       st;
    hpm_pkg::commit_instr_t [`HPM_NR_COMMIT-1:0] ci;
    logic                   [`HPM_NR_COMMIT-1:0] ack;
    logic                                        dbg;
    hpm_pkg::xlen_t                              inh;
    logic                   [31:0]               r;
    inh = '0;
    for (int c = 0; c < cycles; c++) begin
      @(posedge clk_i);
      if (inhibit_on && c % 64 == 0) inh = $random(seed);
      r   = $random(seed);
      st  = hpm_pkg::core_status_t'(r[8:0]);
      ack = r[10:9];
      dbg = debug_on && r[15:13] == 3'd0;  // Roughly one cycle in eight
      for (int p = 0; p < `HPM_NR_COMMIT; p++) begin
        r = $random(seed);
        ci[p].fu      = hpm_pkg::fu_t'(r[2:0] == 3'd7 ? 3'd0 : r[2:0]);
        ci[p].rd      = (r[9:8] == 2'd3) ? r[14:10] : (r[9:8] == 2'd2) ? 5'd5 : {4'd0, r[8]};
        ci[p].is_jalr = r[15];
      end
      status_i        <= st;
      commit_instr_i  <= ci;
      commit_ack_i    <= ack;
      debug_mode_i    <= dbg;
      mcountinhibit_i <= inh;
      for (int k = 0; k < `HPM_NUM_COUNTERS; k++) begin
        if (!dbg && !inh[k + 3] && expected_event(model_sel[k], st, ci, ack)) model_cnt[k] += 1;
      end
    end
    @(posedge clk_i);
    status_i        <= '0;
    commit_instr_i  <= '0;
    commit_ack_i    <= '0;
    debug_mode_i    <= 1'b0;
    mcountinhibit_i <= '0;
  endtask

  always @(negedge clk_i) begin : handshake_monitor
    if (rst_ni) begin
      if (csr_ack_o && !ack_seen) begin
        if (!csr_valid_i) report_mismatch("ack rose without valid");
        ack_count++;
      end
      if (!csr_ack_o && ack_seen && csr_valid_i) report_mismatch("ack fell while valid high");
      if (csr_ack_o && ack_seen && csr_rsp_o !== rsp_seen) report_mismatch("rsp moved under ack");
    end
    ack_seen = csr_ack_o;
    rsp_seen = csr_rsp_o;
  end

  initial begin : main
    hpm_pkg::xlen_t v;
    hpm_pkg::xlen_t lo;
    rst_ni          = 1'b0;
    csr_valid_i     = 1'b0;
    csr_req_i       = '0;
    status_i        = '0;
    commit_instr_i  = '0;
    commit_ack_i    = '0;
    debug_mode_i    = 1'b0;
    mcountinhibit_i = '0;
    for (int k = 0; k < `HPM_NUM_COUNTERS; k++) begin
      model_cnt[k] = '0;
      model_sel[k] = '0;
    end
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    if (csr_ack_o !== 1'b0) report_mismatch("ack high after reset");
    check_data(csr_rsp_o.rdata, '0, "response after reset");
    check_err(csr_rsp_o.err, 1'b0, "response after reset");
    check_all();

    // Selectors keep only 5 bits even for unassigned codes
    for (int k = 0; k < `HPM_NUM_COUNTERS; k++) begin
      v = $random(seed);
      if (k == 0) v[4] = 1'b1;
      write_csr(csr_addr(`HPM_EVT_BASE, k), v);
      model_sel[k] = v[4:0];
    end
    check_all();

    for (int k = 0; k < `HPM_NUM_COUNTERS; k++) begin
      v = 1 + ({$random(seed)} % 15);
      write_csr(csr_addr(`HPM_EVT_BASE, k), v);
      model_sel[k] = v[4:0];
      lo = $random(seed);
      if (k % 2 == 0) lo[31:4] = '1;  // Close to a carry into the high half
      write_csr(csr_addr(`HPM_CNT_LO_BASE, k), lo);
      v = $random(seed);
      write_csr(csr_addr(`HPM_CNT_HI_BASE, k), v);
      model_cnt[k] = {v, lo};
    end
    check_all();
    run_traffic(400, 1'b0, 1'b0);
    check_all();
    run_traffic(400, 1'b1, 1'b1);
    check_all();

    // Range edges first, then random addresses
    for (int k = 0; k < 2; k++) begin
      probe_unmapped(csr_addr(`HPM_CNT_LO_BASE, k ? `HPM_NUM_COUNTERS : -1));
      probe_unmapped(csr_addr(`HPM_CNT_HI_BASE, k ? `HPM_NUM_COUNTERS : -1));
      probe_unmapped(csr_addr(`HPM_EVT_BASE, k ? `HPM_NUM_COUNTERS : -1));
    end
    for (int k = 0; k < 24; k++) begin
      probe_unmapped(hpm_pkg::csr_addr_t'($random(seed)));
    end
    check_all();

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
